// ==== include/lgn_consts.svh ====
`ifndef LGN_CONSTS_SVH
`define LGN_CONSTS_SVH

// image as loaded by the host
`define LGN_INPUTS            64
`define LGN_BYTES_PER_IMAGE   8

// gate network sizes
`define LGN_LAYER1_GATES      160
`define LGN_LAYER2_GATES      150

// classification
`define LGN_CATEGORIES        10
`define LGN_BITS_PER_CATEGORY 15  // categories * bits = layer two size
`define LGN_SCORE_WIDTH       4   // holds a count up to 15

// gate j, input a: (MUL_A * j + ADD_A) mod n_in
`define LGN_WIRE_MUL_A        7
`define LGN_WIRE_ADD_A        1

// gate j, input b: (MUL_B * j + ADD_B) mod n_in
`define LGN_WIRE_MUL_B        13
`define LGN_WIRE_ADD_B        5

// gate j, function: (OP_MUL * j + layer) mod 16
`define LGN_OP_MUL            5

`endif

// ==== src/lgn_net_pkg.sv ====
`include "lgn_consts.svh"

package lgn_net_pkg;

  // pixel data
  typedef logic [`LGN_INPUTS-1:0] image_t;
  typedef logic [`LGN_INPUTS/`LGN_BYTES_PER_IMAGE-1:0] pixel_byte_t;

  // layer outputs
  typedef logic [`LGN_LAYER1_GATES-1:0] layer1_t;
  typedef logic [`LGN_LAYER2_GATES-1:0] features_t;  // layer two, split into categories

  // two-input gate functions, value is the truth table
  // bit (2*a + b) holds the output for inputs a, b
  typedef enum logic [3:0] {
    gate_false        = 4'd0,
    gate_nor          = 4'd1,
    gate_not_a_and_b  = 4'd2,
    gate_not_a        = 4'd3,
    gate_a_and_not_b  = 4'd4,
    gate_not_b        = 4'd5,
    gate_xor          = 4'd6,
    gate_nand         = 4'd7,
    gate_and          = 4'd8,
    gate_xnor         = 4'd9,
    gate_b            = 4'd10,
    gate_not_a_or_b   = 4'd11,
    gate_a            = 4'd12,
    gate_a_or_not_b   = 4'd13,
    gate_or           = 4'd14,
    gate_true         = 4'd15
  } gate_op_t;

endpackage

// ==== src/lgn_result_pkg.sv ====
`include "lgn_consts.svh"

package lgn_result_pkg;

  // set-bit count of one category
  typedef logic [`LGN_SCORE_WIDTH-1:0] score_t;

  // winning category, 0 to 9
  typedef logic [$clog2(`LGN_CATEGORIES)-1:0] class_idx_t;

  // bit 0 is segment a, bit 6 is segment g, 1 = lit
  //
  //      a
  //     ---
  //  f |   | b
  //     -g-
  //  e |   | c
  //     ---
  //      d
  typedef logic [6:0] segments_t;

endpackage

// ==== src/pixel_loader.sv ====
`timescale 1ns/1ps
`include "lgn_consts.svh"

module pixel_loader import lgn_net_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        write_enable,
  input  pixel_byte_t pixel_in,
  output image_t      image
);

  localparam int BYTE_W = $bits(pixel_byte_t);

  // shift register, oldest byte ends up at the top
  image_t image_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      image_q <= '0;
    end else if (write_enable) begin
      image_q <= {image_q[`LGN_INPUTS-BYTE_W-1:0], pixel_in};  // new byte at the bottom
    end
  end

  assign image = image_q;

endmodule

// ==== src/logic_gate_layer.sv ====
`timescale 1ns/1ps
`include "lgn_consts.svh"

module logic_gate_layer import lgn_net_pkg::*; #(
  parameter int N_IN     = `LGN_INPUTS,
  parameter int N_OUT    = `LGN_LAYER1_GATES,
  parameter int LAYER_ID = 1
) (
  input  logic [N_IN-1:0]  in_bits,
  output logic [N_OUT-1:0] out_bits
);

  localparam int N_FUNCS = 1 << $bits(gate_op_t);  // 16 two-input functions

  // source of input a for gate j
  function automatic int wire_a(int j);
    int idx;
    idx = (`LGN_WIRE_MUL_A * j + `LGN_WIRE_ADD_A) % N_IN;
    return idx;
  endfunction

  // source of input b for gate j
  function automatic int wire_b(int j);
    int idx;
    idx = (`LGN_WIRE_MUL_B * j + `LGN_WIRE_ADD_B) % N_IN;
    return idx;
  endfunction

  // function of gate j, differs per layer through LAYER_ID
  function automatic gate_op_t gate_fn(int j);
    int code;
    code = (`LGN_OP_MUL * j + LAYER_ID) % N_FUNCS;
    return gate_op_t'(code[3:0]);
  endfunction

  for (genvar j = 0; j < N_OUT; j++) begin : g_gate
    localparam int          IDX_A = wire_a(j);
    localparam int          IDX_B = wire_b(j);
    localparam gate_op_t    OP    = gate_fn(j);
    localparam logic [3:0]  TRUTH = OP;  // table lookup below

    logic a;
    logic b;

    assign a = in_bits[IDX_A];
    assign b = in_bits[IDX_B];

    // pick the truth table bit at 2*a + b
    assign out_bits[j] = TRUTH[{a, b}];
  end

endmodule

// ==== src/gate_network.sv ====
`timescale 1ns/1ps
`include "lgn_consts.svh"

module gate_network import lgn_net_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  image_t    image,
  output features_t features
);

  layer1_t   layer1;
  features_t layer2;
  features_t features_q;

  // image to first layer
  logic_gate_layer #(
    .N_IN     (`LGN_INPUTS),
    .N_OUT    (`LGN_LAYER1_GATES),
    .LAYER_ID (1)
  ) u_layer1 (
    .in_bits  (image),
    .out_bits (layer1)
  );

  // second layer, feeds the categories
  logic_gate_layer #(
    .N_IN     (`LGN_LAYER1_GATES),
    .N_OUT    (`LGN_LAYER2_GATES),
    .LAYER_ID (2)
  ) u_layer2 (
    .in_bits  (layer1),
    .out_bits (layer2)
  );

  // one cycle after the image register
  always_ff @(posedge clk) begin
    if (reset) begin
      features_q <= '0;
    end else begin
      features_q <= layer2;
    end
  end

  assign features = features_q;

endmodule

// ==== src/class_scorer.sv ====
`timescale 1ns/1ps
`include "lgn_consts.svh"

module class_scorer import lgn_net_pkg::*, lgn_result_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  features_t  features,
  output class_idx_t best_class,
  output score_t     best_score,
  output segments_t  segments
);

  score_t     scores [`LGN_CATEGORIES];

  score_t     val_s1 [5];  // pairs 0/1 .. 8/9
  class_idx_t idx_s1 [5];
  score_t     val_s2 [3];
  class_idx_t idx_s2 [3];

  score_t     win_score;
  class_idx_t win_class;
  segments_t  win_segments;

  class_idx_t best_class_q;
  score_t     best_score_q;
  segments_t  segments_q;

  // popcount per category
  always_comb begin
    for (int c = 0; c < `LGN_CATEGORIES; c++) begin
      scores[c] = '0;
      for (int k = 0; k < `LGN_BITS_PER_CATEGORY; k++) begin
        scores[c] = scores[c] + score_t'(features[c*`LGN_BITS_PER_CATEGORY + k]);
      end
    end
  end

  // arg-max tree, strict > so a tie goes to the higher index
  always_comb begin
    for (int i = 0; i < 5; i++) begin
      if (scores[2*i] > scores[2*i+1]) begin
        val_s1[i] = scores[2*i];
        idx_s1[i] = class_idx_t'(2*i);
      end else begin
        val_s1[i] = scores[2*i+1];
        idx_s1[i] = class_idx_t'(2*i+1);
      end
    end

    for (int i = 0; i < 2; i++) begin
      if (val_s1[2*i] > val_s1[2*i+1]) begin
        val_s2[i] = val_s1[2*i];
        idx_s2[i] = idx_s1[2*i];
      end else begin
        val_s2[i] = val_s1[2*i+1];
        idx_s2[i] = idx_s1[2*i+1];
      end
    end
    val_s2[2] = val_s1[4];  // odd one out, passes straight through
    idx_s2[2] = idx_s1[4];

    // final three-way pick
    if (val_s2[0] > val_s2[1]) begin
      if (val_s2[0] > val_s2[2]) begin
        win_score = val_s2[0];
        win_class = idx_s2[0];
      end else begin
        win_score = val_s2[2];
        win_class = idx_s2[2];
      end
    end else if (val_s2[1] > val_s2[2]) begin
      win_score = val_s2[1];
      win_class = idx_s2[1];
    end else begin
      win_score = val_s2[2];
      win_class = idx_s2[2];
    end
  end

  // digit pattern, gfedcba
  always_comb begin
    case (win_class)
      4'd0:    win_segments = 7'h3f;
      4'd1:    win_segments = 7'h06;
      4'd2:    win_segments = 7'h5b;
      4'd3:    win_segments = 7'h4f;
      4'd4:    win_segments = 7'h66;
      4'd5:    win_segments = 7'h6d;
      4'd6:    win_segments = 7'h7c;
      4'd7:    win_segments = 7'h07;
      4'd8:    win_segments = 7'h7f;
      4'd9:    win_segments = 7'h67;
      default: win_segments = 7'h00;  // blank
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      best_class_q <= '0;
      best_score_q <= '0;
      segments_q   <= '0;  // display off
    end else begin
      best_class_q <= win_class;
      best_score_q <= win_score;
      segments_q   <= win_segments;
    end
  end

  assign best_class = best_class_q;
  assign best_score = best_score_q;
  assign segments   = segments_q;

endmodule

// ==== src/lgn_classifier_top.sv ====
`timescale 1ns/1ps

module lgn_classifier_top import lgn_net_pkg::*, lgn_result_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  pixel_byte_t pixel_in,
  input  logic        write_enable,
  output class_idx_t  best_class,
  output score_t      best_score,
  output segments_t   segments
);

  image_t    image;     // loader to network
  features_t features;  // network to scorer

  // decode
  pixel_loader u_pixel_loader (
    .clk          (clk),
    .reset        (reset),
    .write_enable (write_enable),
    .pixel_in     (pixel_in),
    .image        (image)
  );

  // execute
  gate_network u_gate_network (
    .clk      (clk),
    .reset    (reset),
    .image    (image),
    .features (features)
  );

  // result
  class_scorer u_class_scorer (
    .clk        (clk),
    .reset      (reset),
    .features   (features),
    .best_class (best_class),
    .best_score (best_score),
    .segments   (segments)
  );

endmodule

// ==== tb/lgn_classifier_tb.sv ====
`timescale 1ns/1ps
`include "lgn_consts.svh"

module lgn_classifier_tb import lgn_net_pkg::*, lgn_result_pkg::*; ();

  localparam int N_TABLE   = 8;
  localparam int N_RANDOM  = 50;
  localparam int MAX_RANDOM = 200;  // keeps drawing until some ties are seen
  localparam int N_STREAM  = 30;

  logic        clk;
  logic        reset;
  pixel_byte_t pixel_in;
  logic        write_enable;
  class_idx_t  best_class;
  score_t      best_score;
  segments_t   segments;

  int unsigned edge_count = 0;
  logic [31:0] lcg_state;
  image_t      model_image;  // image register as the loading rule predicts it

  // stimulus table
  image_t    tbl_image [N_TABLE];
  class_idx_t tbl_class [N_TABLE];
  score_t    tbl_score [N_TABLE];
  segments_t tbl_seg   [N_TABLE];

  lgn_classifier_top dut0 (
    .clk          (clk),
    .reset        (reset),
    .pixel_in     (pixel_in),
    .write_enable (write_enable),
    .best_class   (best_class),
    .best_score   (best_score),
    .segments     (segments)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    edge_count = edge_count + 1;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic pixel_byte_t rand_byte();
    logic [31:0] r;
    r = lcg_next();
    return r[31:24];  // upper bits, the low ones cycle quickly
  endfunction

  // output of one gate from its truth-table code
  function automatic logic gate_eval(int op, logic a, logic b);
    int sel;
    sel = (a ? 2 : 0) + (b ? 1 : 0);
    return (op >> sel) & 1;
  endfunction

  function automatic layer1_t model_layer1(image_t img);
    layer1_t out;
    int ia;
    int ib;
    for (int j = 0; j < `LGN_LAYER1_GATES; j++) begin
      ia = (7 * j + 1) % `LGN_INPUTS;
      ib = (13 * j + 5) % `LGN_INPUTS;
      out[j] = gate_eval((5 * j + 1) % 16, img[ia], img[ib]);
    end
    return out;
  endfunction

  function automatic features_t model_layer2(layer1_t l1);
    features_t out;
    int ia;
    int ib;
    for (int j = 0; j < `LGN_LAYER2_GATES; j++) begin
      ia = (7 * j + 1) % `LGN_LAYER1_GATES;
      ib = (13 * j + 5) % `LGN_LAYER1_GATES;
      out[j] = gate_eval((5 * j + 2) % 16, l1[ia], l1[ib]);
    end
    return out;
  endfunction

  function automatic segments_t digit_segments(int d);
    case (d)
      0: return 7'h3f;
      1: return 7'h06;
      2: return 7'h5b;
      3: return 7'h4f;
      4: return 7'h66;
      5: return 7'h6d;
      6: return 7'h7c;
      7: return 7'h07;
      8: return 7'h7f;
      9: return 7'h67;
      default: return 7'h00;
    endcase
  endfunction

  // full reference: network, category counts, arg-max, display
  task automatic model_classify(input image_t img, output class_idx_t cls,
                                output score_t sc, output segments_t seg, output bit tied);
    features_t f;
    int cnt;
    int best;
    int best_c;
    int n_best;
    f = model_layer2(model_layer1(img));
    best = -1;
    best_c = 0;
    n_best = 0;
    for (int c = 0; c < `LGN_CATEGORIES; c++) begin
      cnt = 0;
      for (int k = 0; k < `LGN_BITS_PER_CATEGORY; k++) begin
        cnt += f[c * `LGN_BITS_PER_CATEGORY + k];
      end
      if (cnt > best) begin
        best = cnt;
        best_c = c;
        n_best = 1;
      end else if (cnt == best) begin
        best_c = c;  // ties go to the higher index
        n_best++;
      end
    end
    cls = class_idx_t'(best_c);
    sc = score_t'(best);
    seg = digit_segments(best_c);
    tied = (n_best > 1);
  endtask

  task automatic fail_value(string msg);
    $display("** Error at %t: %s", $realtime, msg);
    $display("Test failed");
    $fatal(1, "output mismatch");
  endtask

  task automatic check_class(class_idx_t got, class_idx_t exp, string tag);
    if (got !== exp) begin
      fail_value($sformatf("%s: best_class is %0d, expected %0d", tag, got, exp));
    end
  endtask

  task automatic check_score(score_t got, score_t exp, string tag);
    if (got !== exp) begin
      fail_value($sformatf("%s: best_score is %0d, expected %0d", tag, got, exp));
    end
  endtask

  task automatic check_segments(segments_t got, segments_t exp, string tag);
    if (got !== exp) begin
      fail_value($sformatf("%s: segments is %h, expected %h", tag, got, exp));
    end
  endtask

  task automatic check_outputs(class_idx_t cls, score_t sc, segments_t seg, string tag);
    check_class(best_class, cls, tag);
    check_score(best_score, sc, tag);
    check_segments(segments, seg, tag);
  endtask

  // check the outputs against the model of one image
  task automatic check_model(input image_t img, input string tag, output bit tied);
    class_idx_t cls;
    score_t     sc;
    segments_t  seg;
    model_classify(img, cls, sc, seg, tied);
    check_outputs(cls, sc, seg, tag);
  endtask

  // polls in 1 ns steps, so from 0.5 ns after an edge it lands 0.5 ns after the target edge
  task automatic wait_edges(int n);
    int unsigned target;
    int polls;
    target = edge_count + n;
    polls = 0;
    while (edge_count < target && polls < 4 * n + 8) begin
      #1;
      polls++;
    end
    if (edge_count < target) begin
      $display("timeout: the clock stopped before %0d edges had passed", n);
      $display("Test failed");
      $fatal(1, "clock timeout");
    end
  endtask

  task automatic write_byte(pixel_byte_t b);
    pixel_in = b;
    write_enable = 1'b1;
    wait_edges(1);
    model_image = {model_image[`LGN_INPUTS-9:0], b};
  endtask

  // first byte ends up in bits 63..56
  task automatic load_image(image_t img);
    for (int i = `LGN_BYTES_PER_IMAGE - 1; i >= 0; i--) begin
      write_byte(img[8*i +: 8]);
    end
    write_enable = 1'b0;
  endtask

  task automatic build_table();
    bit tied;
    tbl_image[0] = 64'h0000_0000_0000_0000;
    tbl_image[1] = 64'hffff_ffff_ffff_ffff;
    tbl_image[2] = 64'haaaa_aaaa_aaaa_aaaa;  // alternating
    tbl_image[3] = 64'h0000_00ff_0000_0000;  // one byte set
    tbl_image[4] = 64'h5555_5555_5555_5555;
    tbl_image[5] = 64'hf0f0_f0f0_f0f0_f0f0;
    tbl_image[6] = 64'h0123_4567_89ab_cdef;
    tbl_image[7] = 64'hffff_0000_ffff_0000;
    for (int i = 0; i < N_TABLE; i++) begin
      model_classify(tbl_image[i], tbl_class[i], tbl_score[i], tbl_seg[i], tied);
    end
  endtask

  initial begin
    image_t      img;
    image_t      burst_img;
    image_t      older;
    image_t      old;
    pixel_byte_t burst [10];
    class_idx_t  hold_class;
    score_t      hold_score;
    segments_t   hold_seg;
    bit          tied;
    int          ties;
    int          n_rand;

    $timeformat(-9, 1, " ns", 0);
    reset = 1'b1;
    write_enable = 1'b0;
    pixel_in = '0;
    lcg_state = 32'h870d_09fa;
    model_image = '0;
    build_table();

    #0.5;  // drive skew after each rising edge
    wait_edges(4);
    reset = 1'b0;

    // outputs cleared, nothing written yet
    check_outputs('0, '0, '0, "after reset");

    for (int i = 0; i < N_TABLE; i++) begin
      load_image(tbl_image[i]);
      wait_edges(2);
      check_outputs(tbl_class[i], tbl_score[i], tbl_seg[i], $sformatf("table entry %0d", i));
    end

    ties = 0;
    n_rand = 0;
    while (n_rand < N_RANDOM || (ties < 3 && n_rand < MAX_RANDOM)) begin
      img = {lcg_next(), lcg_next()};
      load_image(img);
      wait_edges(2);
      check_model(img, $sformatf("random image %0d", n_rand), tied);
      if (tied) begin
        ties++;
      end
      n_rand++;
    end
    if (ties == 0) begin
      $display("no random image produced a tied arg-max, so the tie rule went unchecked");
      $display("Test failed");
      $fatal(1, "tie rule not exercised");
    end

    // ten bytes, the first two fall off the top
    for (int i = 0; i < 10; i++) begin
      burst[i] = rand_byte();
      write_byte(burst[i]);
    end
    write_enable = 1'b0;
    for (int i = 2; i < 10; i++) begin
      burst_img[8*(9-i) +: 8] = burst[i];
    end
    wait_edges(2);
    check_model(burst_img, "ten byte burst", tied);

    // write_enable low, pixel_in wiggling
    model_classify(model_image, hold_class, hold_score, hold_seg, tied);
    for (int i = 0; i < 10; i++) begin
      pixel_in = rand_byte();
      wait_edges(1);
      check_outputs(hold_class, hold_score, hold_seg, $sformatf("hold cycle %0d", i));
    end

    // one write per cycle, outputs trail the image by two edges
    older = model_image;
    old = model_image;
    for (int s = 0; s < N_STREAM; s++) begin
      write_byte(rand_byte());
      check_model(older, $sformatf("stream cycle %0d", s), tied);
      older = old;
      old = model_image;
    end
    write_enable = 1'b0;
    wait_edges(2);
    check_model(model_image, "after stream", tied);

    $display("Test passed");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+include
src/lgn_net_pkg.sv
src/lgn_result_pkg.sv
src/pixel_loader.sv
src/logic_gate_layer.sv
src/gate_network.sv
src/class_scorer.sv
src/lgn_classifier_top.sv
tb/lgn_classifier_tb.sv

// ==== Bender.yml ====
package:
  name: lgn_classifier

export_include_dirs:
  - include

sources:
  # packages first, then the blocks bottom up
  - include_dirs:
      - include
    files:
      - src/lgn_net_pkg.sv
      - src/lgn_result_pkg.sv
      - src/pixel_loader.sv
      - src/logic_gate_layer.sv
      - src/gate_network.sv
      - src/class_scorer.sv
      - src/lgn_classifier_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - tb/lgn_classifier_tb.sv
